/* all.f */
design/tx_pkg.sv
design/tx_clock_divider.sv
design/hr_16t4_mux.sv
design/qr_4t1_mux.sv
design/tx_top.sv
testbench/tb_clock_gen.sv
testbench/tx_sva.sv
testbench/tx_tb.sv

/* Bender.yml */
package:
  name: tx_serializer

sources:
  # Design, package first
  - files:
      - design/tx_pkg.sv
      - design/tx_clock_divider.sv
      - design/hr_16t4_mux.sv
      - design/qr_4t1_mux.sv
      - design/tx_top.sv

  # Testbench with bound assertions, top module tx_tb
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tx_sva.sv
      - testbench/tx_tb.sv

/* testbench/tx_tb.sv */
`default_nettype none

module tx_tb;

    import tx_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_SER      = 40;     // Plain serialization words
    localparam int N_GATE     = 10;     // Words with cke gaps
    localparam int N_SLIP     = 10;     // Words with slip pulses
    localparam int N_FLUSH    = 2;      // Drain the words in flight
    localparam int N_WORDS    = 1 + N_SER + N_GATE + N_SLIP + N_FLUSH;
    localparam int TIMEOUT    = (N_WORDS * WORD_W * 2 + 5) * CLK_PERIOD;

    logic              ext_clk;
    logic              arst_n;
    logic              cke;
    logic              bit_slip;
    logic [WORD_W-1:0] din;
    logic              clk_prbsgen;
    logic              dout_p;
    logic              dout_n;

    logic [31:0]       lcg_state = 32'd51;
    logic              word_clk_q = 1'b0;   // Last seen ungated clk_prbsgen
    int                errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;

    tb_clock_gen u_clk_gen (
        .clk (ext_clk)
    );

    tx_top u_tx_top (
        .ext_clk     (ext_clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .bit_slip    (bit_slip),
        .din         (din),
        .clk_prbsgen (clk_prbsgen),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    ////////////////////
    // Random source
    ////////////////////

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [WORD_W-1:0] random_word();
        logic [31:0] s;
        s = lcg_step();
        return s[30:15];            // Upper bits, low ones cycle too fast
    endfunction

    function automatic int random_between(input int lo, input int hi);
        logic [31:0] s;
        s = lcg_step();
        return lo + int'(s[30:16]) % (hi - lo + 1);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    logic [CNT_W-1:0] slot_m = '0;      // Bit slot inside the word
    logic             exp_bit = 1'b0;   // Raw bit after the last edge
    logic             bit_q[$];         // Bits still to come, in order
    int               words_sampled = 0;

    // Inputs are stable at the edge, driven 10 units after the previous one
    always @(posedge ext_clk) begin
        if (!arst_n) begin
            slot_m  = '0;
            exp_bit = 1'b0;
            bit_q.delete();
            // Zeros until bit 0 of the first word, sampled after slot 15
            repeat (WORD_W - 1 + LOAD_LAT) bit_q.push_back(1'b0);
        end else if (!cke && !bit_slip) begin
            if (slot_m == CNT_W'(WORD_W - 1)) begin
                for (int i = 0; i < WORD_W; i++) begin
                    bit_q.push_back(din[i]);    // LSB first
                end
                words_sampled++;
            end
            if (bit_q.size() == 0) begin
                $display("Model ran out of bits at time %0t", $time);
                errors++;
            end else begin
                exp_bit = bit_q.pop_front();
            end
            slot_m = slot_m + 1'b1;             // Wraps with the word
        end
        // Gated or slipped cycle, everything holds
    end

    ////////////////////
    // Checks
    ////////////////////

    // Mid-cycle, all outputs settled
    always @(negedge ext_clk) begin : check_outputs
        logic exp_p;
        logic exp_clk;
        exp_p   = exp_bit & ~cke;
        exp_clk = (slot_m >= CNT_W'(WORD_W / 2)) & ~cke;   // Slots 8..15
        dout_p_value: assert (dout_p === exp_p) else begin
            $display("Error dout_p expected %h actual %h at %0t", exp_p, dout_p, $time);
            errors++;
        end
        clk_value: assert (clk_prbsgen === exp_clk) else begin
            $display("Error clk_prbsgen expected %h actual %h at %0t",
                     exp_clk, clk_prbsgen, $time);
            errors++;
        end
    end

    // A slip repeats the bit and holds the word clock for one cycle
    slip_holds: assert property (@(posedge ext_clk) disable iff (!arst_n)
        (bit_slip && !cke) ##1 !cke |-> $stable(dout_p) && $stable(clk_prbsgen))
        else begin
            $display("Output moved in the cycle after a bit slip at %0t", $time);
            errors++;
        end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Next word goes out after each rising edge of the word clock
    task automatic next_cycle();
        @(posedge ext_clk);
        #10;
        if (arst_n && !cke) begin
            if (clk_prbsgen && !word_clk_q) begin
                din = random_word();
            end
            word_clk_q = clk_prbsgen;
        end
    endtask

    function automatic int total_fails();
        return errors + u_tx_top.u_tx_sva.fail_cnt;
    endfunction

    task automatic finish_test(input string name, input int fails_before);
        int fails_now;
        fails_now = total_fails();
        tests_run++;
        if (fails_now != fails_before) begin
            tests_failed++;
        end
        $display("Test %-10s finished, %0d failed checks", name, fails_now - fails_before);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : run_tests
        int fails_before;
        int target;
        arst_n   = 1'b0;
        cke      = 1'b0;
        bit_slip = 1'b0;
        din      = random_word();

        // Reset held 5 cycles, released mid-cycle
        fails_before = total_fails();
        repeat (5) @(posedge ext_clk);
        #10;
        arst_n = 1'b1;
        repeat (2) next_cycle();
        finish_test("reset", fails_before);

        // Plain stream of random words
        fails_before = total_fails();
        target = words_sampled + N_SER;
        while (words_sampled < target) next_cycle();
        finish_test("serialize", fails_before);

        // Gaps of cke at random slots
        fails_before = total_fails();
        target = words_sampled + N_GATE;
        while (words_sampled < target) begin
            repeat (random_between(4, 19)) next_cycle();
            cke = 1'b1;
            repeat (random_between(1, 6)) next_cycle();
            cke = 1'b0;
        end
        finish_test("gating", fails_before);

        // Single-cycle slip pulses
        fails_before = total_fails();
        target = words_sampled + N_SLIP;
        while (words_sampled < target) begin
            repeat (random_between(5, 20)) next_cycle();
            bit_slip = 1'b1;
            next_cycle();
            bit_slip = 1'b0;
        end
        // Drain what is still in flight
        target = words_sampled + N_FLUSH;
        while (words_sampled < target) next_cycle();
        repeat (LOAD_LAT + WORD_W) next_cycle();
        finish_test("bit_slip", fails_before);

        $display("Tests run %0d, failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_fails());
        if (total_fails() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Bound from the word count, two periods per bit slot
    initial begin : watchdog
        #(TIMEOUT);
        $display("Watchdog expired, tests did not finish within %0d time units", TIMEOUT);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tx_sva.sv */
`default_nettype none

module tx_sva (
    input logic ext_clk,
    input logic arst_n,
    input logic cke,
    input logic bit_slip,
    input logic clk_prbsgen,
    input logic dout_p,
    input logic dout_n
);

    import tx_pkg::*;

    int fail_cnt = 0;       // Failed assertions, read by the testbench
    int adv_cnt;            // Advancing edges since reset, saturates

    // Bit 0 of the first word is out after WORD_W + LOAD_LAT advancing edges
    always_ff @(posedge ext_clk or negedge arst_n) begin
        if (!arst_n) begin
            adv_cnt <= 0;
        end else if (!cke && !bit_slip && adv_cnt < WORD_W + LOAD_LAT) begin
            adv_cnt <= adv_cnt + 1;
        end
    end

    ////////////////////
    // Reset
    ////////////////////

    reset_quiet: assert property (@(posedge ext_clk)
        !arst_n |-> !dout_p && !dout_n && !clk_prbsgen)
        else begin
            $error("Outputs not low during reset");
            fail_cnt++;
        end

    // Cycle after the first edge out of reset, still all low
    reset_exit_quiet: assert property (@(posedge ext_clk)
        $rose(arst_n) |=> !dout_p && !dout_n && !clk_prbsgen)
        else begin
            $error("Outputs not low in the first cycle after reset");
            fail_cnt++;
        end

    ////////////////////
    // Gating and pair
    ////////////////////

    gated_low: assert property (@(posedge ext_clk)
        cke |-> !dout_p && !dout_n && !clk_prbsgen)
        else begin
            $error("Outputs not low while cke is high");
            fail_cnt++;
        end

    pair_inverse: assert property (@(posedge ext_clk) disable iff (!arst_n)
        (adv_cnt == WORD_W + LOAD_LAT) && !cke |-> dout_n == !dout_p)
        else begin
            $error("dout_n is not the inverse of dout_p");
            fail_cnt++;
        end

endmodule

bind tx_top tx_sva u_tx_sva (
    .ext_clk     (ext_clk),
    .arst_n      (arst_n),
    .cke         (cke),
    .bit_slip    (bit_slip),
    .clk_prbsgen (clk_prbsgen),
    .dout_p      (dout_p),
    .dout_n      (dout_n)
);

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int PERIOD = 100;    // One serial bit slot

    // Free-running, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* design/tx_top.sv */
`default_nettype none

module tx_top (
    input  logic                        ext_clk,        // Serial bit-rate clock
    input  logic                        arst_n,
    input  logic                        cke,            // High gates the transmitter off
    input  logic                        bit_slip,       // Delays the word boundary by one bit
    // Next word must be stable before the falling edge of clk_prbsgen
    // No back-pressure, the source follows the word clock
    input  logic [tx_pkg::WORD_W-1:0]   din,
    output logic                        clk_prbsgen,    // Word clock for the data source
    output logic                        dout_p,         // Serial data, true
    output logic                        dout_n          // Serial data, inverted
);

    import tx_pkg::*;

    logic             advance;
    q_phase_e         phase;
    logic             load_word;
    logic             load_nibble;
    logic [NIB_W-1:0] qr_data_p;        // 16:4 output, positive chain
    logic [NIB_W-1:0] qr_data_n;        // 16:4 output, negative chain
    logic             ser_p;            // Raw serial bits before gating
    logic             ser_n;

    ////////////////////
    // Slot timing
    ////////////////////

    tx_clock_divider u_clk_div (
        .ext_clk     (ext_clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .bit_slip    (bit_slip),
        .advance     (advance),
        .phase       (phase),
        .load_word   (load_word),
        .load_nibble (load_nibble),
        .clk_prbsgen (clk_prbsgen)
    );

    ////////////////////
    // Serializer chains
    ////////////////////

    // Positive chain
    hr_16t4_mux u_hr_mux_p (
        .ext_clk   (ext_clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .load_word (load_word),
        .phase     (phase),
        .din       (din),
        .dout      (qr_data_p)
    );

    qr_4t1_mux u_qr_mux_p (
        .ext_clk     (ext_clk),
        .arst_n      (arst_n),
        .advance     (advance),
        .load_nibble (load_nibble),
        .din         (qr_data_p),
        .data        (ser_p)
    );

    // Negative chain, inverted word for the differential pair
    hr_16t4_mux u_hr_mux_n (
        .ext_clk   (ext_clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .load_word (load_word),
        .phase     (phase),
        .din       (~din),
        .dout      (qr_data_n)
    );

    qr_4t1_mux u_qr_mux_n (
        .ext_clk     (ext_clk),
        .arst_n      (arst_n),
        .advance     (advance),
        .load_nibble (load_nibble),
        .din         (qr_data_n),
        .data        (ser_n)
    );

    // Both legs low while gated, state underneath holds
    assign dout_p = ser_p & ~cke;
    assign dout_n = ser_n & ~cke;

endmodule

`default_nettype wire

/* design/qr_4t1_mux.sv */
`default_nettype none

module qr_4t1_mux (
    input  logic                        ext_clk,
    input  logic                        arst_n,
    input  logic                        advance,        // Slot enable
    input  logic                        load_nibble,    // Last slot of a phase
    input  logic [tx_pkg::NIB_W-1:0]    din,            // Nibble from the 16:4 stage
    output logic                        data            // Registered serial bit
);

    import tx_pkg::*;

    logic [NIB_W-2:0] shift_q;      // Bits still waiting to go out

    ////////////////////
    // Nibble shifter
    ////////////////////

    // LSB first, bit 0 reaches data at the load edge itself
    always_ff @(posedge ext_clk or negedge arst_n) begin
        if (!arst_n) begin
            data    <= 1'b0;
            shift_q <= '0;
        end else if (advance) begin
            if (load_nibble) begin
                data    <= din[0];              // First bit straight out
                shift_q <= din[NIB_W-1:1];      // Keep the upper three
            end else begin
                data    <= shift_q[0];
                shift_q <= {1'b0, shift_q[NIB_W-2:1]};
            end
        end
        // No advance, so the current bit repeats
    end

endmodule

`default_nettype wire

/* design/hr_16t4_mux.sv */
`default_nettype none

module hr_16t4_mux (
    input  logic                        ext_clk,
    input  logic                        arst_n,
    input  logic                        advance,    // Slot enable
    input  logic                        load_word,  // Last slot of the word
    input  tx_pkg::q_phase_e            phase,      // Current quarter-rate slot
    input  logic [tx_pkg::WORD_W-1:0]   din,        // Parallel word from the source
    output logic [tx_pkg::NIB_W-1:0]    dout        // Nibble for the 4:1 stage
);

    import tx_pkg::*;

    logic [WORD_W-1:0] word_q;      // Word being serialized

    ////////////////////
    // Word register
    ////////////////////

    // Old word stays until its IB nibble is taken at the same edge
    always_ff @(posedge ext_clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q <= '0;
        end else if (advance && load_word) begin
            word_q <= din;
        end
    end

    ////////////////////
    // Nibble select
    ////////////////////

    // Nibble of the current slot is taken at its last edge
    // and shifted out during the following slot
    always_comb begin
        case (phase)
            PH_Q:    dout = word_q[0*NIB_W +: NIB_W];  // Bits 3:0
            PH_I:    dout = word_q[1*NIB_W +: NIB_W];  // Bits 7:4
            PH_QB:   dout = word_q[2*NIB_W +: NIB_W];  // Bits 11:8
            PH_IB:   dout = word_q[3*NIB_W +: NIB_W];  // Bits 15:12
            default: dout = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/tx_clock_divider.sv */
`default_nettype none

module tx_clock_divider (
    input  logic              ext_clk,      // Serial bit-rate clock
    input  logic              arst_n,
    input  logic              cke,          // High gates the transmitter off
    input  logic              bit_slip,     // One-cycle step of the word boundary
    output logic              advance,      // Slot enable for all stages
    output tx_pkg::q_phase_e  phase,        // Current quarter-rate slot
    output logic              load_word,    // Capture din into the word register
    output logic              load_nibble,  // Load next nibble into the shifter
    output logic              clk_prbsgen   // Word-rate clock to the data source
);

    import tx_pkg::*;

    logic [CNT_W-1:0] bit_cnt;              // Bit slot inside the word

    ////////////////////
    // Slot counter
    ////////////////////

    // Hold on gating or slip, a slip costs exactly one cycle
    assign advance = ~cke & ~bit_slip;

    always_ff @(posedge ext_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
        end else if (advance) begin
            bit_cnt <= bit_cnt + CNT_W'(1);     // Wraps 15 -> 0
        end
    end

    ////////////////////
    // Phase and strobes
    ////////////////////

    // Upper counter bits select the quarter-rate phase
    assign phase = q_phase_e'(bit_cnt[CNT_W-1 -: $bits(q_phase_e)]);

    // Last slot of each phase, the shifter takes a fresh nibble
    assign load_nibble = advance & (&bit_cnt[CNT_W-$bits(q_phase_e)-1:0]);

    // Last slot of the word
    // New word enters as the final nibble leaves the old one
    assign load_word = advance & (&bit_cnt);

    ////////////////////
    // Word-rate clock
    ////////////////////

    // MSB is high in slots 8..15, falls as din is sampled
    assign clk_prbsgen = bit_cnt[CNT_W-1] & ~cke;   // Gated low with the transmitter

endmodule

`default_nettype wire

/* design/tx_pkg.sv */
`default_nettype none

package tx_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////

    // Parallel word from the upstream source
    localparam int WORD_W = 16;

    // Quarter-rate nibble, one per phase slot
    localparam int NIB_W = 4;

    // Bit-slot counter inside one word
    localparam int CNT_W = 4;   // 2**CNT_W slots == WORD_W bits

    // Word-sample edge to first serial bit, in advancing cycles
    // One full nibble slot through the word register and select
    localparam int LOAD_LAT = 4;

    ////////////////////
    // Quarter-rate phases
    ////////////////////

    // Rising-edge order of the quarter-rate clocks
    // Q -> I -> QB -> IB -> Q, evenly spaced in one word
    // Encoded as the upper two bits of the slot counter
    typedef enum logic [1:0] {
        PH_Q  = 2'd0,           // Slots 0..3
        PH_I  = 2'd1,           // Slots 4..7
        PH_QB = 2'd2,           // Slots 8..11
        PH_IB = 2'd3            // Slots 12..15
    } q_phase_e;

endpackage

`default_nettype wire
